//--- list.f
+incdir+source
source/dacfifo_pkg.sv
source/dacfifo_ctrl.sv
source/dacfifo_addr_cnt.sv
source/dacfifo_wr_pack.sv
source/dacfifo_mem.sv
source/dacfifo_rd_unpack.sv
source/dacfifo_bypass.sv
source/dacfifo_top.sv
verif/dacfifo_tb.sv

//--- run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module dacfifo_tb \
  -f list.f -o dacfifo_sim &&
./obj_dir/dacfifo_sim | tee /dev/stderr | grep -qx "Everything OK" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

//--- verif/dacfifo_tb.sv
// testbench for the DAC sample buffer
// drives DMA transfers, replay requests and bypass traffic, assertions do the checking
`timescale 1ns/10ps
`include "dacfifo_cfg.svh"

module dacfifo_tb;

  localparam int PERIOD   = 40;
  localparam int CAPACITY = `DACFIFO_LINES * `DACFIFO_BEATS_PER_LINE;
  localparam int DEPTH    = `DACFIFO_BYPASS_DEPTH;
  // rough length of each test in cycles
  localparam int LEN_RESET   = 20;
  localparam int LEN_LOAD    = 80;
  localparam int LEN_GAPS    = 60;
  localparam int LEN_FULL    = 200;
  localparam int LEN_RESTART = 120;
  localparam int LEN_BYPASS  = 100;
  localparam int RUN_LIMIT   = 2 * PERIOD *
    (LEN_RESET + LEN_LOAD + LEN_GAPS + LEN_FULL + LEN_RESTART + LEN_BYPASS);

  logic                          dac_clk;
  logic                          reset;
  logic                          dma_valid;
  logic [`DACFIFO_DMA_WIDTH-1:0] dma_data;
  logic                          dma_xfer_req;
  logic                          dma_xfer_last;
  logic                          dac_valid;
  logic                          bypass;
  logic                          dma_ready;
  logic [`DACFIFO_DAC_WIDTH-1:0] dac_data;
  logic                          dac_dunf;
  logic                          dac_xfer_out;

  // reference model state
  logic [`DACFIFO_DMA_WIDTH-1:0] load_q [$];
  logic [`DACFIFO_DMA_WIDTH-1:0] byp_fifo [$];
  int                            rep_idx;
  int                            byp_cnt;
  logic [`DACFIFO_DAC_WIDTH-1:0] exp_data;
  logic                          exp_dunf;
  logic                          exp_req;
  logic                          exp_byp;
  logic                          byp_q;
  logic                          req_prev;
  logic                          req_rise;
  logic                          rise_q;
  logic                          load_closed;
  logic                          idle_chk;
  logic                          play_chk;
  int                            err_cnt;
  int                            err_mark;
  int                            test_cnt;
  int                            taken;

  dacfifo_top dacfifo_top_i (
    .dac_clk (dac_clk), .reset (reset), .dma_valid (dma_valid), .dma_data (dma_data),
    .dma_xfer_req (dma_xfer_req), .dma_xfer_last (dma_xfer_last), .dac_valid (dac_valid),
    .bypass (bypass), .dma_ready (dma_ready), .dac_data (dac_data), .dac_dunf (dac_dunf),
    .dac_xfer_out (dac_xfer_out));

  initial begin
    dac_clk = 1'b0;
    forever #(PERIOD / 2) dac_clk = ~dac_clk;
  end

  // ************************************************************
  // reference model, updated on the same edges as the DUT

  assign req_rise = dma_xfer_req & ~req_prev & ~byp_q;

  always @(posedge dac_clk) begin
    if (reset) begin
      req_prev    <= 1'b0;
      byp_q       <= 1'b0;
      exp_byp     <= 1'b0;
      exp_req     <= 1'b0;
      exp_dunf    <= 1'b0;
      exp_data    <= '0;
      rise_q      <= 1'b0;
      load_closed <= 1'b0;
      byp_cnt     <= 0;
      rep_idx     = 0;
      load_q.delete();
      byp_fifo.delete();
    end else begin
      req_prev <= dma_xfer_req;
      byp_q    <= bypass;
      exp_byp  <= byp_q;
      exp_req  <= dma_xfer_req;
      rise_q   <= req_rise;
      if (byp_q) begin
        // pop sees the queue before this edge's push
        exp_dunf <= dac_valid && byp_fifo.size() == 0;
        if (dac_valid && byp_fifo.size() != 0) begin
          exp_data <= byp_fifo.pop_front();
        end
        if (dma_valid && dma_ready) begin
          byp_fifo.push_back(dma_data);
        end
      end else begin
        exp_dunf <= dac_valid && !dac_xfer_out;
        byp_fifo.delete();
        if (dac_valid && dac_xfer_out && load_q.size() != 0) begin
          exp_data <= load_q[rep_idx];
          rep_idx = (rep_idx + 1 == load_q.size()) ? 0 : rep_idx + 1;
        end
        if (req_rise) begin
          load_q.delete();
          rep_idx = 0;
          load_closed <= 1'b0;
        end else if (dma_valid && dma_ready) begin
          load_q.push_back(dma_data);
          if (dma_xfer_last || load_q.size() == CAPACITY) begin
            load_closed <= 1'b1;
          end
        end
      end
      byp_cnt <= byp_fifo.size();
    end
  end

  // ************************************************************
  // checks

  a_data: assert property (@(posedge dac_clk) disable iff (reset)
    dac_data == exp_data) else report_mismatch("dac_data differs from the expected sample");

  a_dunf: assert property (@(posedge dac_clk) disable iff (reset)
    dac_dunf == exp_dunf) else report_mismatch("dac_dunf differs from the expected flag");

  a_no_dunf_play: assert property (@(posedge dac_clk) disable iff (reset)
    play_chk |-> !dac_dunf) else report_mismatch("dac_dunf raised during replay");

  a_byp_xfer: assert property (@(posedge dac_clk) disable iff (reset)
    exp_byp |-> dac_xfer_out == exp_req) else report_mismatch("dac_xfer_out not following req");

  a_restart: assert property (@(posedge dac_clk) disable iff (reset)
    rise_q |=> !dac_xfer_out) else report_mismatch("dac_xfer_out stayed high on restart");

  a_closed: assert property (@(posedge dac_clk) disable iff (reset)
    !byp_q && load_closed |-> !dma_ready) else report_mismatch("dma_ready high after load end");

  a_byp_full: assert property (@(posedge dac_clk) disable iff (reset)
    byp_q && byp_cnt == DEPTH |-> !dma_ready) else report_mismatch("dma_ready high, queue full");

  a_idle: assert property (@(posedge dac_clk) disable iff (reset)
    idle_chk |-> !dma_ready && !dac_xfer_out) else report_mismatch("outputs active after reset");

  task automatic report_mismatch(input string msg);
    err_cnt++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  task automatic report_problem(input string msg);
    err_cnt++;
    $display("%s", msg);
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    $display("test %0d %s finished, %0d errors", test_cnt, name, err_cnt - err_mark);
    err_mark = err_cnt;
  endtask

  // offers up to n beats, gives up after stall_limit cycles without ready
  task automatic offer_beats(input int n, input bit mark_last, input int stall_limit,
                             output int count);
    logic [`DACFIFO_DMA_WIDTH-1:0] word;
    int                            stall;
    count = 0;
    stall = 0;
    word  = $urandom;
    while (count < n && stall < stall_limit) begin
      @(negedge dac_clk);
      dma_valid     = 1'b1;
      dma_data      = word;
      dma_xfer_last = mark_last && (count == n - 1);
      if (dma_ready) begin
        count++;
        stall = 0;
        word  = $urandom;
      end else begin
        stall++;
      end
    end
    @(negedge dac_clk);
    dma_valid     = 1'b0;
    dma_xfer_last = 1'b0;
  endtask

  task automatic send_transfer(input int n, input int stall_limit, output int count);
    @(negedge dac_clk);
    dma_xfer_req = 1'b1;
    offer_beats(n, 1'b1, stall_limit, count);
    dma_xfer_req = 1'b0;
  endtask

  task automatic wait_xfer_out(input int limit);
    int k;
    k = 0;
    while (!dac_xfer_out && k < limit) begin
      @(negedge dac_clk);
      k++;
    end
    if (!dac_xfer_out) begin
      report_problem("dac_xfer_out did not rise after the load finished");
    end
  endtask

  task automatic request_samples(input int n, input int min_gap, input int max_gap);
    int gap;
    for (int k = 0; k < n; k++) begin
      @(negedge dac_clk);
      dac_valid = 1'b1;
      gap = $urandom_range(max_gap, min_gap);
      repeat (gap) begin
        @(negedge dac_clk);
        dac_valid = 1'b0;
      end
    end
    @(negedge dac_clk);
    dac_valid = 1'b0;
  endtask

  // replay strobes, any underflow flag while they run is an error
  task automatic request_replay(input int n, input int min_gap, input int max_gap);
    play_chk = 1'b1;
    request_samples(n, min_gap, max_gap);
    @(negedge dac_clk);
    play_chk = 1'b0;
  endtask

  initial begin
    #(RUN_LIMIT);
    $display("watchdog expired, the tests did not finish in time");
    $display("Something failed");
    $finish;
  end

  initial begin
    void'($urandom(32'h1088));
    reset         = 1'b1;
    dma_valid     = 1'b0;
    dma_data      = '0;
    dma_xfer_req  = 1'b0;
    dma_xfer_last = 1'b0;
    dac_valid     = 1'b0;
    bypass        = 1'b0;
    idle_chk      = 1'b0;
    play_chk      = 1'b0;
    err_cnt       = 0;
    err_mark      = 0;
    test_cnt      = 0;
    repeat (4) @(posedge dac_clk);
    @(negedge dac_clk);
    reset = 1'b0;

    // idle outputs, then a strobe with nothing loaded
    idle_chk = 1'b1;
    repeat (2) @(negedge dac_clk);
    request_samples(1, 0, 0);
    repeat (3) @(negedge dac_clk);
    idle_chk = 1'b0;
    end_test("reset_state");

    // ten beats leave a half filled last line
    send_transfer(10, 8, taken);
    assert (taken == 10) else report_mismatch("short transfer not fully taken");
    wait_xfer_out(20);
    request_replay(25, 0, 0);
    end_test("load_replay");

    request_replay(12, 1, 3);
    end_test("gapped_requests");

    send_transfer(CAPACITY + 6, 8, taken);
    assert (taken == CAPACITY) else report_mismatch("full memory took a wrong beat count");
    wait_xfer_out(20);
    request_replay(CAPACITY + 8, 0, 0);
    end_test("full_memory");

    send_transfer(6, 8, taken);
    wait_xfer_out(20);
    request_replay(5, 0, 0);
    // second request arrives while the first transfer still plays
    send_transfer(7, 8, taken);
    assert (taken == 7) else report_mismatch("restart transfer not fully taken");
    wait_xfer_out(20);
    request_replay(10, 0, 1);
    end_test("restart");

    @(negedge dac_clk);
    bypass = 1'b1;
    repeat (3) @(negedge dac_clk);
    request_samples(1, 0, 0);
    dma_xfer_req = 1'b1;
    offer_beats(DEPTH + 2, 1'b0, 4, taken);
    assert (taken == DEPTH) else report_mismatch("bypass queue took a wrong beat count");
    request_samples(DEPTH, 0, 0);
    request_samples(1, 0, 0);
    offer_beats(3, 1'b0, 4, taken);
    request_samples(3, 0, 1);
    dma_xfer_req = 1'b0;
    repeat (3) @(negedge dac_clk);
    bypass = 1'b0;
    repeat (3) @(negedge dac_clk);
    end_test("bypass");

    $display("tests run %0d, check failures %0d", test_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- source/dacfifo_top.sv
// DAC sample buffer top level
// loads one DMA transfer into line memory and loops it to the DAC
`timescale 1ns/10ps
`include "dacfifo_cfg.svh"

module dacfifo_top (
  input  logic                              dac_clk,
  input  logic                              reset,
  input  logic                              dma_valid,
  input  logic [`DACFIFO_DMA_WIDTH-1:0]     dma_data,
  input  logic                              dma_xfer_req,
  input  logic                              dma_xfer_last,
  input  logic                              dac_valid,
  input  logic                              bypass,
  output logic                              dma_ready,
  output logic [`DACFIFO_DAC_WIDTH-1:0]     dac_data,
  output logic                              dac_dunf,
  output logic                              dac_xfer_out
);

  // bypass exists only when both sides carry the same sample width
  localparam bit FIFO_BYPASS = (`DACFIFO_DAC_WIDTH == `DACFIFO_DMA_WIDTH);

  logic                              bypass_q;
  dacfifo_pkg::xfer_state_t          state;
  dacfifo_pkg::line_wr_t             line_wr;
  dacfifo_pkg::xfer_end_t            xfer_end;
  logic                              load_done;
  logic                              primed;
  logic                              line_done;
  logic                              beat_last;
  logic [`DACFIFO_BEAT_WIDTH-1:0]    last_beats;
  logic [`DACFIFO_ADDR_WIDTH-1:0]    wr_addr;
  logic [`DACFIFO_ADDR_WIDTH-1:0]    rd_addr;
  logic                              rd_en;
  logic                              rd_step;
  logic [`DACFIFO_LINE_WIDTH-1:0]    rd_data;
  logic                              dma_ready_wr;
  logic [`DACFIFO_DAC_WIDTH-1:0]     fifo_sample;
  logic                              fifo_valid;
  logic                              fifo_dunf;
  logic [`DACFIFO_DAC_WIDTH-1:0]     sel_sample;
  logic                              sel_valid;
  logic                              sel_dunf;
  logic                              sel_xfer;

  always_ff @(posedge dac_clk) begin
    if (reset) begin
      bypass_q <= 1'b0;
    end else begin
      bypass_q <= bypass & FIFO_BYPASS;
    end
  end

  dacfifo_ctrl dacfifo_ctrl_i (
    .dac_clk (dac_clk), .reset (reset), .dma_xfer_req (dma_xfer_req), .bypass (bypass_q),
    .load_done (load_done), .primed (primed), .state (state));

  dacfifo_wr_pack dacfifo_wr_pack_i (
    .dac_clk (dac_clk), .reset (reset), .state (state), .dma_valid (dma_valid),
    .dma_data (dma_data), .dma_xfer_last (dma_xfer_last), .wr_addr (wr_addr),
    .dma_ready (dma_ready_wr), .line_wr (line_wr), .line_done (line_done),
    .beat_last (beat_last), .last_beats (last_beats));

  dacfifo_addr_cnt dacfifo_addr_cnt_i (
    .dac_clk (dac_clk), .reset (reset), .state (state), .line_done (line_done),
    .beat_last (beat_last), .last_beats (last_beats), .rd_step (rd_step),
    .wr_addr (wr_addr), .rd_addr (rd_addr), .xfer_end (xfer_end), .load_done (load_done));

  dacfifo_mem dacfifo_mem_i (
    .dac_clk (dac_clk), .line_wr (line_wr), .rd_en (rd_en), .rd_addr (rd_addr),
    .rd_data (rd_data));

  dacfifo_rd_unpack dacfifo_rd_unpack_i (
    .dac_clk (dac_clk), .reset (reset), .state (state), .dac_valid (dac_valid),
    .xfer_end (xfer_end), .rd_addr (rd_addr), .rd_data (rd_data), .rd_en (rd_en),
    .rd_step (rd_step), .primed (primed), .sample (fifo_sample),
    .sample_valid (fifo_valid), .dunf (fifo_dunf));

  // ***********************************************************
  // path select

  generate
    if (FIFO_BYPASS) begin : g_bypass
      logic                          byp_ready;
      logic [`DACFIFO_DAC_WIDTH-1:0] byp_sample;
      logic                          byp_valid;
      logic                          byp_dunf;

      dacfifo_bypass dacfifo_bypass_i (
        .dac_clk (dac_clk), .reset (reset), .active (bypass_q), .dma_valid (dma_valid),
        .dma_data (dma_data), .dac_valid (dac_valid), .dma_ready (byp_ready),
        .sample (byp_sample), .sample_valid (byp_valid), .dunf (byp_dunf));

      assign dma_ready  = bypass_q ? byp_ready : dma_ready_wr;
      assign sel_sample = bypass_q ? byp_sample : fifo_sample;
      assign sel_valid  = bypass_q ? byp_valid : fifo_valid;
      assign sel_dunf   = bypass_q ? byp_dunf : fifo_dunf;
      // in bypass the request level itself frames the output
      assign sel_xfer   = bypass_q ? dma_xfer_req : primed;
    end else begin : g_fifo_only
      assign dma_ready  = dma_ready_wr;
      assign sel_sample = fifo_sample;
      assign sel_valid  = fifo_valid;
      assign sel_dunf   = fifo_dunf;
      assign sel_xfer   = primed;
    end
  endgenerate

  // registered DAC outputs, data holds when nothing is handed out
  always_ff @(posedge dac_clk) begin
    if (reset) begin
      dac_data     <= '0;
      dac_dunf     <= 1'b0;
      dac_xfer_out <= 1'b0;
    end else begin
      if (sel_valid) begin
        dac_data <= sel_sample;
      end
      dac_dunf     <= sel_dunf;
      dac_xfer_out <= sel_xfer;
    end
  end

endmodule

//--- source/dacfifo_bypass.sv
// small sample queue for the bypass path
// DMA beats go straight to the DAC in arrival order
`timescale 1ns/10ps
`include "dacfifo_cfg.svh"

module dacfifo_bypass (
  input  logic                              dac_clk,
  input  logic                              reset,
  input  logic                              active,
  input  logic                              dma_valid,
  input  logic [`DACFIFO_DMA_WIDTH-1:0]     dma_data,
  input  logic                              dac_valid,
  output logic                              dma_ready,
  output logic [`DACFIFO_DAC_WIDTH-1:0]     sample,
  output logic                              sample_valid,
  output logic                              dunf
);

  localparam int AW = $clog2(`DACFIFO_BYPASS_DEPTH);

  logic [`DACFIFO_DMA_WIDTH-1:0] queue [`DACFIFO_BYPASS_DEPTH];
  logic [AW:0]                   wr_ptr;
  logic [AW:0]                   rd_ptr;
  logic [AW:0]                   wr_ptr_nxt;
  logic [AW:0]                   rd_ptr_nxt;
  logic                          push;
  logic                          pop;
  logic                          empty;
  logic                          full;
  logic                          full_nxt;

  // pointers carry one extra wrap bit
  assign empty = (wr_ptr == rd_ptr);
  assign full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign push  = dma_valid & dma_ready;
  assign pop   = dac_valid & ~empty;

  assign wr_ptr_nxt = wr_ptr + {{AW{1'b0}}, push};
  assign rd_ptr_nxt = rd_ptr + {{AW{1'b0}}, pop};
  assign full_nxt   = (wr_ptr_nxt[AW] != rd_ptr_nxt[AW]) &&
                      (wr_ptr_nxt[AW-1:0] == rd_ptr_nxt[AW-1:0]);

  assign sample       = queue[rd_ptr[AW-1:0]];
  assign sample_valid = pop;
  assign dunf         = dac_valid & empty;

  // ready looks one cycle ahead at the occupancy
  always_ff @(posedge dac_clk) begin
    if (reset || !active) begin
      wr_ptr    <= '0;
      rd_ptr    <= '0;
      dma_ready <= 1'b0;
    end else begin
      wr_ptr    <= wr_ptr_nxt;
      rd_ptr    <= rd_ptr_nxt;
      dma_ready <= ~full_nxt;
    end
  end

  always_ff @(posedge dac_clk) begin
    if (push) begin
      queue[wr_ptr[AW-1:0]] <= dma_data;
    end
  end

  a_no_push_full: assert property (@(posedge dac_clk) disable iff (reset)
    full |-> !push);

endmodule

//--- source/dacfifo_rd_unpack.sv
// replays stored lines one sample per DAC strobe
// keeps a current and a prefetched line so full rate never starves
`timescale 1ns/10ps
`include "dacfifo_cfg.svh"

module dacfifo_rd_unpack (
  input  logic                              dac_clk,
  input  logic                              reset,
  input  dacfifo_pkg::xfer_state_t          state,
  input  logic                              dac_valid,
  input  dacfifo_pkg::xfer_end_t            xfer_end,
  input  logic [`DACFIFO_ADDR_WIDTH-1:0]    rd_addr,
  input  logic [`DACFIFO_LINE_WIDTH-1:0]    rd_data,
  output logic                              rd_en,
  output logic                              rd_step,
  output logic                              primed,
  output logic [`DACFIFO_DAC_WIDTH-1:0]     sample,
  output logic                              sample_valid,
  output logic                              dunf
);

  localparam int W = `DACFIFO_DAC_WIDTH;

  logic                           playing;
  logic                           pend;
  logic                           pend_last;
  logic                           cur_vld;
  logic                           cur_last;
  logic                           nxt_vld;
  logic                           nxt_last;
  logic                           primed_r;
  logic                           primed_q;
  logic                           pop;
  logic                           cur_done;
  logic [`DACFIFO_BEAT_WIDTH-1:0] beat;
  logic [`DACFIFO_BEAT_WIDTH-1:0] cur_end;
  logic [`DACFIFO_LINE_WIDTH-1:0] cur_line;
  logic [`DACFIFO_LINE_WIDTH-1:0] nxt_line;

  assign playing = (state == dacfifo_pkg::XFER_PLAY);

  // one read in flight at a time, issued once the next buffer is free or frees now
  assign rd_en   = playing & ~pend & (~nxt_vld | cur_done);
  assign rd_step = rd_en;

  // primed_q lines up with dac_xfer_out at the top
  assign primed   = primed_r & playing;
  assign pop      = dac_valid & primed_q & cur_vld;
  assign cur_end  = cur_last ? xfer_end.last_beats : '1;
  assign cur_done = pop & (beat == cur_end);

  assign sample       = cur_line[beat*W +: W];
  assign sample_valid = pop;
  assign dunf         = dac_valid & ~pop;

  always_ff @(posedge dac_clk) begin
    if (reset || !playing) begin
      pend     <= 1'b0;
      cur_vld  <= 1'b0;
      nxt_vld  <= 1'b0;
      beat     <= '0;
      primed_r <= 1'b0;
    end else begin
      pend     <= rd_en;
      primed_r <= primed_r | (pend & cur_vld);
      if (cur_done) begin
        beat    <= '0;
        cur_vld <= nxt_vld | pend;
        nxt_vld <= nxt_vld & pend;
      end else begin
        if (pop) begin
          beat <= beat + 1'b1;
        end
        if (pend) begin
          cur_vld <= 1'b1;
          nxt_vld <= cur_vld;
        end
      end
    end
  end

  always_ff @(posedge dac_clk) begin
    if (reset) begin
      primed_q <= 1'b0;
    end else begin
      primed_q <= primed;
    end
  end

  // ***********************************************************
  // line buffers

  always_ff @(posedge dac_clk) begin
    if (rd_en) begin
      pend_last <= (rd_addr == xfer_end.last_addr);
    end
    if (cur_done) begin
      cur_line <= nxt_vld ? nxt_line : rd_data;
      cur_last <= nxt_vld ? nxt_last : pend_last;
      if (pend) begin
        nxt_line <= rd_data;
        nxt_last <= pend_last;
      end
    end else if (pend) begin
      if (cur_vld) begin
        nxt_line <= rd_data;
        nxt_last <= pend_last;
      end else begin
        cur_line <= rd_data;
        cur_last <= pend_last;
      end
    end
  end

  // prefetch keeps up with a strobe on every cycle
  a_no_dunf_primed: assert property (@(posedge dac_clk) disable iff (reset)
    primed_q |-> !dunf);

endmodule

//--- source/dacfifo_mem.sv
// line memory with one write port and a registered read port
`timescale 1ns/10ps
`include "dacfifo_cfg.svh"

module dacfifo_mem (
  input  logic                              dac_clk,
  input  dacfifo_pkg::line_wr_t             line_wr,
  input  logic                              rd_en,
  input  logic [`DACFIFO_ADDR_WIDTH-1:0]    rd_addr,
  output logic [`DACFIFO_LINE_WIDTH-1:0]    rd_data
);

  logic [`DACFIFO_LINE_WIDTH-1:0] lines [`DACFIFO_LINES];

  always_ff @(posedge dac_clk) begin
    if (line_wr.en) begin
      lines[line_wr.addr] <= line_wr.data;
    end
  end

  // read data is valid the cycle after rd_en
  always_ff @(posedge dac_clk) begin
    if (rd_en) begin
      rd_data <= lines[rd_addr];
    end
  end

endmodule

//--- source/dacfifo_wr_pack.sv
// packs DMA beats into memory lines
// a short final line goes out early, zero padded
`timescale 1ns/10ps
`include "dacfifo_cfg.svh"

module dacfifo_wr_pack (
  input  logic                              dac_clk,
  input  logic                              reset,
  input  dacfifo_pkg::xfer_state_t          state,
  input  logic                              dma_valid,
  input  logic [`DACFIFO_DMA_WIDTH-1:0]     dma_data,
  input  logic                              dma_xfer_last,
  input  logic [`DACFIFO_ADDR_WIDTH-1:0]    wr_addr,
  output logic                              dma_ready,
  output dacfifo_pkg::line_wr_t             line_wr,
  output logic                              line_done,
  output logic                              beat_last,
  output logic [`DACFIFO_BEAT_WIDTH-1:0]    last_beats
);

  localparam int W  = `DACFIFO_DMA_WIDTH;
  localparam int BW = `DACFIFO_BEAT_WIDTH;
  localparam int AW = `DACFIFO_ADDR_WIDTH;
  localparam logic [BW-1:0] LAST_BEAT = BW'(`DACFIFO_BEATS_PER_LINE - 1);
  localparam logic [AW-1:0] LAST_LINE = AW'(`DACFIFO_LINES - 1);

  logic                           loading;
  logic                           take;
  logic                           line_full;
  logic                           flush;
  logic                           ending;
  logic                           ended;
  logic [BW-1:0]                  beat;
  logic                           wr_en;
  logic [AW-1:0]                  wr_line_addr;
  logic [`DACFIFO_LINE_WIDTH-1:0] wr_line_data;
  logic [`DACFIFO_LINE_WIDTH-1:0] line_q;
  logic [`DACFIFO_LINE_WIDTH-1:0] line_nxt;

  assign loading   = (state == dacfifo_pkg::XFER_LOAD);
  assign take      = dma_valid & dma_ready;
  assign line_full = (beat == LAST_BEAT);
  assign flush     = line_full | dma_xfer_last;
  // last beat of the stream, or the beat that fills the memory
  assign ending    = dma_xfer_last | (line_full & (wr_addr == LAST_LINE));

  always_comb begin
    line_nxt = line_q;
    line_nxt[beat*W +: W] = dma_data;
  end

  always_ff @(posedge dac_clk) begin
    if (reset || !loading) begin
      dma_ready <= 1'b0;
      ended     <= 1'b0;
      beat      <= '0;
      wr_en     <= 1'b0;
      beat_last <= 1'b0;
    end else begin
      dma_ready <= ~ended & ~(take & ending);
      wr_en     <= take & flush;
      beat_last <= take & dma_xfer_last;
      if (take) begin
        beat  <= flush ? '0 : beat + 1'b1;
        ended <= ended | ending;
      end
    end
  end

  // line payload, cleared between transfers so padding reads as zero
  always_ff @(posedge dac_clk) begin
    if (!loading) begin
      line_q <= '0;
    end else if (take) begin
      line_q       <= flush ? '0 : line_nxt;
      wr_line_data <= line_nxt;
      // the line counter steps one cycle after line_done
      wr_line_addr <= wr_addr + {{(AW-1){1'b0}}, line_done};
      last_beats   <= beat;
    end
  end

  assign line_wr   = {wr_en, wr_line_addr, wr_line_data};
  assign line_done = wr_en;

  a_take_in_load: assert property (@(posedge dac_clk) disable iff (reset)
    take |-> loading);

endmodule

//--- source/dacfifo_addr_cnt.sv
// write and replay line counters
// also records where a loaded transfer ends
`timescale 1ns/10ps
`include "dacfifo_cfg.svh"

module dacfifo_addr_cnt (
  input  logic                              dac_clk,
  input  logic                              reset,
  input  dacfifo_pkg::xfer_state_t          state,
  input  logic                              line_done,
  input  logic                              beat_last,
  input  logic [`DACFIFO_BEAT_WIDTH-1:0]    last_beats,
  input  logic                              rd_step,
  output logic [`DACFIFO_ADDR_WIDTH-1:0]    wr_addr,
  output logic [`DACFIFO_ADDR_WIDTH-1:0]    rd_addr,
  output dacfifo_pkg::xfer_end_t            xfer_end,
  output logic                              load_done
);

  localparam int AW = `DACFIFO_ADDR_WIDTH;
  localparam logic [AW-1:0] LAST_LINE = AW'(`DACFIFO_LINES - 1);

  logic mem_full;
  logic xfer_done;

  // the line just written was the last one that fits
  assign mem_full  = line_done & (wr_addr == LAST_LINE);
  assign xfer_done = beat_last | mem_full;

  always_ff @(posedge dac_clk) begin
    if (reset || state != dacfifo_pkg::XFER_LOAD) begin
      wr_addr   <= '0;
      load_done <= 1'b0;
    end else begin
      load_done <= xfer_done;
      if (line_done) begin
        wr_addr <= wr_addr + 1'b1;
      end
    end
  end

  always_ff @(posedge dac_clk) begin
    if (reset) begin
      xfer_end <= '0;
    end else if (state == dacfifo_pkg::XFER_LOAD && xfer_done) begin
      xfer_end.last_addr  <= wr_addr;
      xfer_end.last_beats <= beat_last ? last_beats : '1;
    end
  end

  // replay walks lines 0 .. last_addr and wraps
  always_ff @(posedge dac_clk) begin
    if (reset || state != dacfifo_pkg::XFER_PLAY) begin
      rd_addr <= '0;
    end else if (rd_step) begin
      rd_addr <= (rd_addr == xfer_end.last_addr) ? '0 : rd_addr + 1'b1;
    end
  end

  a_rd_in_range: assert property (@(posedge dac_clk) disable iff (reset)
    state == dacfifo_pkg::XFER_PLAY |-> rd_addr <= xfer_end.last_addr);

endmodule

//--- source/dacfifo_ctrl.sv
// transfer FSM of the DAC sample buffer
// a rising dma_xfer_req starts a load, load_done starts the replay
`timescale 1ns/10ps
`include "dacfifo_cfg.svh"

module dacfifo_ctrl (
  input  logic                      dac_clk,
  input  logic                      reset,
  input  logic                      dma_xfer_req,
  input  logic                      bypass,
  input  logic                      load_done,
  input  logic                      primed,
  output dacfifo_pkg::xfer_state_t  state
);

  logic                      req_q;
  logic                      req_rise;
  dacfifo_pkg::xfer_state_t  state_nxt;

  assign req_rise = dma_xfer_req & ~req_q;

  always_ff @(posedge dac_clk) begin
    if (reset) begin
      req_q <= 1'b0;
    end else begin
      req_q <= dma_xfer_req;
    end
  end

  // a new request restarts the load from any state
  always_comb begin
    state_nxt = state;
    if (bypass) begin
      state_nxt = dacfifo_pkg::XFER_IDLE;
    end else if (req_rise) begin
      state_nxt = dacfifo_pkg::XFER_LOAD;
    end else if (state == dacfifo_pkg::XFER_LOAD && load_done) begin
      state_nxt = dacfifo_pkg::XFER_PLAY;
    end
  end

  always_ff @(posedge dac_clk) begin
    if (reset) begin
      state <= dacfifo_pkg::XFER_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // ***********************************************************
  // checks

  a_state_legal: assert property (@(posedge dac_clk) disable iff (reset)
    state inside {dacfifo_pkg::XFER_IDLE, dacfifo_pkg::XFER_LOAD, dacfifo_pkg::XFER_PLAY});

  a_no_idle_to_play: assert property (@(posedge dac_clk) disable iff (reset)
    state == dacfifo_pkg::XFER_IDLE |=> state != dacfifo_pkg::XFER_PLAY);

  // the unpacker only primes after at least one cycle of replay
  a_primed_in_play: assert property (@(posedge dac_clk) disable iff (reset)
    primed |-> $past(state) == dacfifo_pkg::XFER_PLAY);

endmodule

//--- source/dacfifo_pkg.sv
// shared types of the DAC sample buffer
// blocks refer to them as dacfifo_pkg::name
`include "dacfifo_cfg.svh"

package dacfifo_pkg;

  // transfer sequencing
  typedef enum logic [1:0] {
    XFER_IDLE = 2'd0,
    XFER_LOAD = 2'd1,
    XFER_PLAY = 2'd2
  } xfer_state_t;

  // one line write into the memory
  typedef struct packed {
    logic                             en;
    logic [`DACFIFO_ADDR_WIDTH-1:0]   addr;
    logic [`DACFIFO_LINE_WIDTH-1:0]   data;
  } line_wr_t;

  // final line of a transfer and its beat count minus one
  typedef struct packed {
    logic [`DACFIFO_ADDR_WIDTH-1:0]   last_addr;
    logic [`DACFIFO_BEAT_WIDTH-1:0]   last_beats;
  } xfer_end_t;

endpackage

//--- source/dacfifo_cfg.svh
// sizes of the DAC sample buffer
// include in every RTL file and in the testbench
`ifndef DACFIFO_CFG_SVH
`define DACFIFO_CFG_SVH

// sample widths on both sides
`define DACFIFO_DMA_WIDTH       32
`define DACFIFO_DAC_WIDTH       32

// line memory geometry
`define DACFIFO_BEATS_PER_LINE  4
`define DACFIFO_LINE_WIDTH      128
`define DACFIFO_LINES           16
`define DACFIFO_ADDR_WIDTH      4
`define DACFIFO_BEAT_WIDTH      2

// bypass queue
`define DACFIFO_BYPASS_DEPTH    4

`endif
